// File: decodeStage.sv
// Decode stage: control decode, sign extend, register reads, beq resolution, ID/EX register
`timescale 1ns/10ps
module decodeStage (
   input  logic             Clk,
   input  logic             rstN,
   input  logic             stall,
   input  mipsPkg::wordT    instrId,
   input  mipsPkg::wordT    pcPlus4Id,
   input  logic             wbValid,
   input  mipsPkg::regIdxT  wbReg,
   input  mipsPkg::wordT    wbData,
   output mipsPkg::regIdxT  rsId,
   output mipsPkg::regIdxT  rtId,
   output logic             isBranchId,
   output logic             branchTaken,
   output mipsPkg::wordT    branchTarget,
   output mipsPkg::wordT    opA,
   output mipsPkg::wordT    opB,
   output mipsPkg::wordT    immEx,
   output mipsPkg::regIdxT  rsEx,
   output mipsPkg::regIdxT  rtEx,
   output mipsPkg::regIdxT  destEx,
   output mipsPkg::aluCtrlT aluCtrlEx,
   output logic             aluSrcImmEx,
   output logic             regWriteEx,
   output logic             memReadEx,
   output logic             memWriteEx,
   output logic             memToRegEx
);
   mipsPkg::opcodeT  opcode;
   mipsPkg::functT   funct;
   mipsPkg::regIdxT  rdId;
   mipsPkg::regIdxT  dest;
   mipsPkg::immT     imm;
   mipsPkg::wordT    immExt;
   mipsPkg::wordT    rdDataA;
   mipsPkg::wordT    rdDataB;
   mipsPkg::aluCtrlT aluCtrl;
   logic             isR;
   logic             isLw;
   logic             isSw;

   // Field split
   assign opcode = instrId[31:26];
   assign rsId   = instrId[25:21];
   assign rtId   = instrId[20:16];
   assign rdId   = instrId[15:11];
   assign funct  = instrId[5:0];
   assign imm    = instrId[15:0];

   assign isR        = opcode == mipsPkg::opcR;
   assign isLw       = opcode == mipsPkg::opcLw;
   assign isSw       = opcode == mipsPkg::opcSw;
   assign isBranchId = opcode == mipsPkg::opcBeq;

   // R-type writes rd, lw writes rt
   assign dest   = isR ? rdId : rtId;
   assign immExt = {{16{imm[15]}}, imm};

   // lw and sw add, beq subtracts, R-type by function
   always_comb begin
      aluCtrl = mipsPkg::aluAdd;
      if (isBranchId) begin
         aluCtrl = mipsPkg::aluSub;
      end else if (isR) begin
         case (funct)
            mipsPkg::fnSub: aluCtrl = mipsPkg::aluSub;
            mipsPkg::fnAnd: aluCtrl = mipsPkg::aluAnd;
            mipsPkg::fnOr:  aluCtrl = mipsPkg::aluOr;
            mipsPkg::fnSlt: aluCtrl = mipsPkg::aluSlt;
            default:        aluCtrl = mipsPkg::aluAdd;
         endcase
      end
   end

   regFile regFile_i (
      .Clk     (Clk),
      .rstN    (rstN),
      .rdAddrA (rsId),
      .rdAddrB (rtId),
      .wrEn    (wbValid),
      .wrAddr  (wbReg),
      .wrData  (wbData),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB)
   );

   // Early beq resolution, held back while its sources are still in flight
   assign branchTarget = pcPlus4Id + {immExt[29:0], 2'b00};
   assign branchTaken  = isBranchId && !stall && (rdDataA == rdDataB);

   // ID/EX control, bubble on stall
   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         regWriteEx  <= 1'b0;
         memReadEx   <= 1'b0;
         memWriteEx  <= 1'b0;
         memToRegEx  <= 1'b0;
         aluSrcImmEx <= 1'b0;
         aluCtrlEx   <= mipsPkg::aluAdd;
         rsEx        <= '0;
         rtEx        <= '0;
         destEx      <= '0;
      end else begin
         regWriteEx  <= (isR || isLw) && !stall;
         memReadEx   <= isLw && !stall;
         memWriteEx  <= isSw && !stall;
         memToRegEx  <= isLw && !stall;
         aluSrcImmEx <= isLw || isSw;
         aluCtrlEx   <= aluCtrl;
         rsEx        <= rsId;
         rtEx        <= rtId;
         destEx      <= dest;
      end
   end

   // Operand payload
   always_ff @(posedge Clk) begin
      opA   <= rdDataA;
      opB   <= rdDataB;
      immEx <= immExt;
   end

endmodule

// File: executeStage.sv
// Execute stage: operand forwarding, ALU, EX/MEM register
`timescale 1ns/10ps
module executeStage (
   input  logic             Clk,
   input  logic             rstN,
   input  mipsPkg::wordT    opA,
   input  mipsPkg::wordT    opB,
   input  mipsPkg::wordT    immEx,
   input  mipsPkg::regIdxT  destEx,
   input  mipsPkg::aluCtrlT aluCtrlEx,
   input  logic             aluSrcImmEx,
   input  logic             regWriteEx,
   input  logic             memReadEx,
   input  logic             memWriteEx,
   input  logic             memToRegEx,
   input  mipsPkg::fwdSelT  fwdA,
   input  mipsPkg::fwdSelT  fwdB,
   input  mipsPkg::wordT    wbData,
   output mipsPkg::wordT    aluResultMem,
   output mipsPkg::wordT    storeDataMem,
   output mipsPkg::regIdxT  destMem,
   output logic             regWriteMem,
   output logic             memReadMem,
   output logic             memWriteMem,
   output logic             memToRegMem
);
   mipsPkg::wordT srcA;
   mipsPkg::wordT srcB;
   mipsPkg::wordT storeData;
   mipsPkg::wordT aluResult;

   // One forward mux shared by both operands
   function automatic mipsPkg::wordT pickOperand(input mipsPkg::fwdSelT sel,
                                                 input mipsPkg::wordT regVal,
                                                 input mipsPkg::wordT memVal,
                                                 input mipsPkg::wordT wbVal);
      case (sel)
         mipsPkg::fwdMem: return memVal;
         mipsPkg::fwdWb:  return wbVal;
         default:         return regVal;
      endcase
   endfunction

   assign srcA      = pickOperand(fwdA, opA, aluResultMem, wbData);
   // Forwarded rt also serves as sw data
   assign storeData = pickOperand(fwdB, opB, aluResultMem, wbData);
   assign srcB      = aluSrcImmEx ? immEx : storeData;

   always_comb begin
      case (aluCtrlEx)
         mipsPkg::aluAdd: aluResult = srcA + srcB;
         mipsPkg::aluSub: aluResult = srcA - srcB;
         mipsPkg::aluAnd: aluResult = srcA & srcB;
         mipsPkg::aluOr:  aluResult = srcA | srcB;
         // Signed compare
         mipsPkg::aluSlt: aluResult = {31'b0, $signed(srcA) < $signed(srcB)};
         default:         aluResult = '0;
      endcase
   end

   // EX/MEM control
   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         destMem     <= '0;
         regWriteMem <= 1'b0;
         memReadMem  <= 1'b0;
         memWriteMem <= 1'b0;
         memToRegMem <= 1'b0;
      end else begin
         destMem     <= destEx;
         regWriteMem <= regWriteEx;
         memReadMem  <= memReadEx;
         memWriteMem <= memWriteEx;
         memToRegMem <= memToRegEx;
      end
   end

   // Result and store payload
   always_ff @(posedge Clk) begin
      aluResultMem <= aluResult;
      storeDataMem <= storeData;
   end

endmodule

// File: fetchStage.sv
// Fetch stage: PC register, loadable instruction memory, IF/ID register
`timescale 1ns/10ps
module fetchStage #(
   parameter int imemWords = 256
) (
   input  logic          Clk,
   input  logic          rstN,
   input  logic          run,
   input  logic          stall,
   input  logic          branchTaken,
   input  mipsPkg::wordT branchTarget,
   input  logic          imemWrEn,
   input  mipsPkg::wordT imemAddr,
   input  mipsPkg::wordT imemData,
   output mipsPkg::wordT instrId,
   output mipsPkg::wordT pcPlus4Id
);
   localparam int idxW = $clog2(imemWords);

   mipsPkg::wordT imem [imemWords];
   mipsPkg::wordT pc;
   mipsPkg::wordT pcPlus4;
   mipsPkg::wordT instrIf;

   // Unloaded words fetch as the all-zero no-op
   initial begin
      for (int i = 0; i < imemWords; i++) begin
         imem[i] = '0;
      end
   end

   // Load port, one word per cycle
   always @(posedge Clk) begin
      if (imemWrEn) begin
         imem[imemAddr[idxW-1:0]] <= imemData;
      end
   end

   // Byte PC, word index from bits above the byte offset
   assign instrIf = imem[pc[idxW+1:2]];
   assign pcPlus4 = pc + 32'd4;

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         pc <= '0;
      end else if (!run) begin
         pc <= '0;
      end else if (branchTaken) begin
         pc <= branchTarget;
      end else if (!stall) begin
         pc <= pcPlus4;
      end
   end

   // IF/ID, squashed to the zero instruction on a taken branch or while idle
   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         instrId   <= '0;
         pcPlus4Id <= '0;
      end else if (!run || branchTaken) begin
         instrId   <= '0;
         pcPlus4Id <= '0;
      end else if (!stall) begin
         instrId   <= instrIf;
         pcPlus4Id <= pcPlus4;
      end
   end

endmodule

// File: hazardUnit.sv
// Hazard unit: EX forward selects, load-use stall, beq source stall
`timescale 1ns/10ps
module hazardUnit (
   input  mipsPkg::regIdxT rsId,
   input  mipsPkg::regIdxT rtId,
   input  logic            isBranchId,
   input  mipsPkg::regIdxT rsEx,
   input  mipsPkg::regIdxT rtEx,
   input  mipsPkg::regIdxT destEx,
   input  logic            regWriteEx,
   input  logic            memReadEx,
   input  mipsPkg::regIdxT destMem,
   input  logic            regWriteMem,
   input  mipsPkg::regIdxT destWb,
   input  logic            regWriteWb,
   output logic            stall,
   output mipsPkg::fwdSelT fwdA,
   output mipsPkg::fwdSelT fwdB
);
   logic loadUse;
   logic branchWait;

   // Producer writes a nonzero register that the consumer reads
   function automatic logic hits(input logic wr, input mipsPkg::regIdxT dest,
                                 input mipsPkg::regIdxT src);
      return wr && (dest != '0) && (dest == src);
   endfunction

   // Younger producer in MEM wins over WB
   assign fwdA = hits(regWriteMem, destMem, rsEx) ? mipsPkg::fwdMem :
                 hits(regWriteWb, destWb, rsEx)   ? mipsPkg::fwdWb  : mipsPkg::fwdNone;
   assign fwdB = hits(regWriteMem, destMem, rtEx) ? mipsPkg::fwdMem :
                 hits(regWriteWb, destWb, rtEx)   ? mipsPkg::fwdWb  : mipsPkg::fwdNone;

   // Loaded word not ready until WB
   assign loadUse = hits(memReadEx, destEx, rsId) || hits(memReadEx, destEx, rtId);

   // beq compares in ID, so it waits until the producer reaches WB
   // and the register file bypass covers it
   assign branchWait = isBranchId &&
                       (hits(regWriteEx, destEx, rsId)   || hits(regWriteEx, destEx, rtId) ||
                        hits(regWriteMem, destMem, rsId) || hits(regWriteMem, destMem, rtId));

   assign stall = loadUse || branchWait;

endmodule

// File: memoryStage.sv
// Memory stage: data memory, store strobes, MEM/WB register, writeback mux
`timescale 1ns/10ps
module memoryStage #(
   parameter int dmemWords = 256
) (
   input  logic            Clk,
   input  logic            rstN,
   input  mipsPkg::wordT   aluResultMem,
   input  mipsPkg::wordT   storeDataMem,
   input  mipsPkg::regIdxT destMem,
   input  logic            regWriteMem,
   input  logic            memReadMem,
   input  logic            memWriteMem,
   input  logic            memToRegMem,
   output logic            memWrEn,
   output mipsPkg::wordT   memAddr,
   output mipsPkg::wordT   memData,
   output logic            wbValid,
   output mipsPkg::regIdxT wbReg,
   output mipsPkg::wordT   wbData,
   output logic            regWriteWb,
   output mipsPkg::regIdxT destWb
);
   localparam int idxW = $clog2(dmemWords);

   mipsPkg::wordT    dmem [dmemWords];
   logic [idxW-1:0]  wordIdx;
   mipsPkg::wordT    loadData;
   mipsPkg::wordT    aluWb;
   mipsPkg::wordT    loadWb;
   logic             memToRegWb;

   // Data starts cleared
   initial begin
      for (int i = 0; i < dmemWords; i++) begin
         dmem[i] = '0;
      end
   end

   // Word index from low address bits, alignment ignored
   assign wordIdx = aluResultMem[idxW-1:0];

   always @(posedge Clk) begin
      if (memWriteMem) begin
         dmem[wordIdx] <= storeDataMem;
      end
   end

   assign loadData = memReadMem ? dmem[wordIdx] : '0;

   // Store strobe in the MEM cycle
   assign memWrEn = memWriteMem;
   assign memAddr = mipsPkg::wordT'(wordIdx);
   assign memData = storeDataMem;

   // MEM/WB control
   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         regWriteWb <= 1'b0;
         memToRegWb <= 1'b0;
         destWb     <= '0;
      end else begin
         regWriteWb <= regWriteMem;
         memToRegWb <= memToRegMem;
         destWb     <= destMem;
      end
   end

   always_ff @(posedge Clk) begin
      aluWb  <= aluResultMem;
      loadWb <= loadData;
   end

   // Writes to r0 are dropped here
   assign wbValid = regWriteWb && (destWb != '0);
   assign wbReg   = destWb;
   assign wbData  = memToRegWb ? loadWb : aluWb;

endmodule

// File: mipsCore.sv
// Five-stage MIPS subset core, top level
`timescale 1ns/10ps
module mipsCore #(
   parameter int imemWords = 256,
   parameter int dmemWords = 256
) (
   input  logic            Clk,
   input  logic            rstN,
   input  logic            run,
   input  logic            imemWrEn,
   input  mipsPkg::wordT   imemAddr,
   input  mipsPkg::wordT   imemData,
   output logic            wbValid,
   output mipsPkg::regIdxT wbReg,
   output mipsPkg::wordT   wbData,
   output logic            memWrEn,
   output mipsPkg::wordT   memAddr,
   output mipsPkg::wordT   memData
);
   // IF/ID
   mipsPkg::wordT    instrId;
   mipsPkg::wordT    pcPlus4Id;
   // Decode outputs
   mipsPkg::regIdxT  rsId;
   mipsPkg::regIdxT  rtId;
   logic             isBranchId;
   logic             branchTaken;
   mipsPkg::wordT    branchTarget;
   // ID/EX
   mipsPkg::wordT    opA;
   mipsPkg::wordT    opB;
   mipsPkg::wordT    immEx;
   mipsPkg::regIdxT  rsEx;
   mipsPkg::regIdxT  rtEx;
   mipsPkg::regIdxT  destEx;
   mipsPkg::aluCtrlT aluCtrlEx;
   logic             aluSrcImmEx;
   logic             regWriteEx;
   logic             memReadEx;
   logic             memWriteEx;
   logic             memToRegEx;
   // EX/MEM
   mipsPkg::wordT    aluResultMem;
   mipsPkg::wordT    storeDataMem;
   mipsPkg::regIdxT  destMem;
   logic             regWriteMem;
   logic             memReadMem;
   logic             memWriteMem;
   logic             memToRegMem;
   // MEM/WB
   logic             regWriteWb;
   mipsPkg::regIdxT  destWb;
   // Hazard controls
   logic             stall;
   mipsPkg::fwdSelT  fwdA;
   mipsPkg::fwdSelT  fwdB;

   fetchStage #(.imemWords(imemWords)) fetchStage_i (
      .Clk(Clk), .rstN(rstN), .run(run), .stall(stall),
      .branchTaken(branchTaken), .branchTarget(branchTarget),
      .imemWrEn(imemWrEn), .imemAddr(imemAddr), .imemData(imemData),
      .instrId(instrId), .pcPlus4Id(pcPlus4Id)
   );

   decodeStage decodeStage_i (
      .Clk(Clk), .rstN(rstN), .stall(stall),
      .instrId(instrId), .pcPlus4Id(pcPlus4Id),
      .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
      .rsId(rsId), .rtId(rtId), .isBranchId(isBranchId),
      .branchTaken(branchTaken), .branchTarget(branchTarget),
      .opA(opA), .opB(opB), .immEx(immEx),
      .rsEx(rsEx), .rtEx(rtEx), .destEx(destEx),
      .aluCtrlEx(aluCtrlEx), .aluSrcImmEx(aluSrcImmEx),
      .regWriteEx(regWriteEx), .memReadEx(memReadEx),
      .memWriteEx(memWriteEx), .memToRegEx(memToRegEx)
   );

   hazardUnit hazardUnit_i (
      .rsId(rsId), .rtId(rtId), .isBranchId(isBranchId),
      .rsEx(rsEx), .rtEx(rtEx), .destEx(destEx),
      .regWriteEx(regWriteEx), .memReadEx(memReadEx),
      .destMem(destMem), .regWriteMem(regWriteMem),
      .destWb(destWb), .regWriteWb(regWriteWb),
      .stall(stall), .fwdA(fwdA), .fwdB(fwdB)
   );

   executeStage executeStage_i (
      .Clk(Clk), .rstN(rstN),
      .opA(opA), .opB(opB), .immEx(immEx), .destEx(destEx),
      .aluCtrlEx(aluCtrlEx), .aluSrcImmEx(aluSrcImmEx),
      .regWriteEx(regWriteEx), .memReadEx(memReadEx),
      .memWriteEx(memWriteEx), .memToRegEx(memToRegEx),
      .fwdA(fwdA), .fwdB(fwdB), .wbData(wbData),
      .aluResultMem(aluResultMem), .storeDataMem(storeDataMem), .destMem(destMem),
      .regWriteMem(regWriteMem), .memReadMem(memReadMem),
      .memWriteMem(memWriteMem), .memToRegMem(memToRegMem)
   );

   memoryStage #(.dmemWords(dmemWords)) memoryStage_i (
      .Clk(Clk), .rstN(rstN),
      .aluResultMem(aluResultMem), .storeDataMem(storeDataMem), .destMem(destMem),
      .regWriteMem(regWriteMem), .memReadMem(memReadMem),
      .memWriteMem(memWriteMem), .memToRegMem(memToRegMem),
      .memWrEn(memWrEn), .memAddr(memAddr), .memData(memData),
      .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
      .regWriteWb(regWriteWb), .destWb(destWb)
   );

endmodule

// File: mipsCore_chk.sv
// Bound assertions on mipsCore result strobes, run control and hazard stall
`timescale 1ns/10ps
module mipsCore_chk (
   input logic            Clk,
   input logic            rstN,
   input logic            run,
   input logic            stall,
   input logic            wbValid,
   input mipsPkg::regIdxT wbReg,
   input logic            memWrEn
);

   // r0 writes are dropped before the strobe
   wbNotZero: assert property (@(posedge Clk) disable iff (!rstN) wbValid |-> wbReg != '0)
      else $error("writeback strobe names register 0");

   // Idle core retires nothing, reset included
   idleQuiet: assert property (@(posedge Clk) !run |-> (!wbValid && !memWrEn))
      else $error("result strobe while run is low");

   // Load-use plus beq wait is at most two cycles
   stallShort: assert property (@(posedge Clk) disable iff (!rstN)
                                (stall && $past(stall)) |=> !stall)
      else $error("stall held for more than two cycles");

endmodule

bind mipsCore mipsCore_chk mipsCore_chk_i (
   .Clk(Clk),
   .rstN(rstN),
   .run(run),
   .stall(stall),
   .wbValid(wbValid),
   .wbReg(wbReg),
   .memWrEn(memWrEn)
);

// File: mipsCore_tb.sv
// Testbench for mipsCore: clock and reset, random program, ISA model, compare tasks, verdict
`timescale 1ns/10ps
module mipsCore_tb;
   localparam int imemWords   = 256;
   localparam int dmemWords   = 256;
   localparam int progLen     = 200;
   // Worst case a few cycles per instruction plus pipeline drain
   localparam int runLimit    = progLen * 3 + 100;
   localparam int quietCycles = 20;

   logic            Clk;
   logic            rstN;
   logic            run;
   logic            imemWrEn;
   mipsPkg::wordT   imemAddr;
   mipsPkg::wordT   imemData;
   logic            wbValid;
   mipsPkg::regIdxT wbReg;
   mipsPkg::wordT   wbData;
   logic            memWrEn;
   mipsPkg::wordT   memAddr;
   mipsPkg::wordT   memData;

   // Program image, last word is the self-loop
   mipsPkg::wordT   prog [progLen + 1];
   mipsPkg::wordT   modelRegs [32];
   mipsPkg::wordT   modelMem [dmemWords];
   // Expected events in program order
   mipsPkg::regIdxT expWbReg [$];
   mipsPkg::wordT   expWbData [$];
   mipsPkg::wordT   expStAddr [$];
   mipsPkg::wordT   expStData [$];
   logic [31:0]     lcgState;
   int              valueErrors = 0;
   int              eventErrors = 0;
   int              missing;
   int              cycles;

   mipsCore #(
      .imemWords(imemWords),
      .dmemWords(dmemWords)
   ) mipsCore_i (
      .Clk(Clk), .rstN(rstN), .run(run),
      .imemWrEn(imemWrEn), .imemAddr(imemAddr), .imemData(imemData),
      .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
      .memWrEn(memWrEn), .memAddr(memAddr), .memData(memData)
   );

   initial begin
      Clk = 1'b0;
      forever #2 Clk = ~Clk;
   end

   // LCG step, upper half only since low bits cycle fast
   function automatic int unsigned pick(input int unsigned n);
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return (lcgState >> 16) % n;
   endfunction

   // Initial data word, odd multiplier spreads every address bit
   function automatic mipsPkg::wordT fillWord(input int idx);
      return (mipsPkg::wordT'(idx) * 32'h045d9f3b) ^ 32'h5a5a0f0f;
   endfunction

   task automatic genProgram();
      int unsigned     kind;
      int              off;
      mipsPkg::regIdxT rs;
      mipsPkg::regIdxT rt;
      mipsPkg::regIdxT rd;
      mipsPkg::functT  fn;
      for (int i = 0; i < progLen; i++) begin
         kind = pick(10);
         // r0..r7 keeps dependencies close together
         rs = mipsPkg::regIdxT'(pick(8));
         rt = mipsPkg::regIdxT'(pick(8));
         rd = mipsPkg::regIdxT'(pick(8));
         if (kind < 5) begin
            case (pick(5))
               0: fn = mipsPkg::fnAdd;
               1: fn = mipsPkg::fnSub;
               2: fn = mipsPkg::fnAnd;
               3: fn = mipsPkg::fnOr;
               default: fn = mipsPkg::fnSlt;
            endcase
            prog[i] = {mipsPkg::opcR, rs, rt, rd, 5'd0, fn};
         end else if (kind < 7) begin
            prog[i] = {mipsPkg::opcLw, rs, rt, mipsPkg::immT'(pick(65536))};
         end else if (kind < 9) begin
            prog[i] = {mipsPkg::opcSw, rs, rt, mipsPkg::immT'(pick(65536))};
         end else begin
            off = int'(pick(4));
            // Never jump past the self-loop
            if (i + 1 + off > progLen) begin
               off = progLen - 1 - i;
            end
            prog[i] = {mipsPkg::opcBeq, rs, rt, mipsPkg::immT'(off)};
         end
      end
      // beq $0,$0,-1 parks the core
      prog[progLen] = {mipsPkg::opcBeq, 5'd0, 5'd0, 16'hffff};
   endtask

   task automatic writeModelReg(input mipsPkg::regIdxT idx, input mipsPkg::wordT val);
      // r0 writes vanish
      if (idx != '0) begin
         modelRegs[idx] = val;
         expWbReg.push_back(idx);
         expWbData.push_back(val);
      end
   endtask

   // In-order ISA execution, no delay slot
   task automatic runModel();
      int              pc;
      int              idx;
      mipsPkg::wordT   ins;
      mipsPkg::regIdxT rs;
      mipsPkg::regIdxT rt;
      mipsPkg::regIdxT rd;
      mipsPkg::immT    imm;
      mipsPkg::wordT   a;
      mipsPkg::wordT   b;
      mipsPkg::wordT   ext;
      mipsPkg::wordT   res;
      pc = 0;
      while (pc < progLen) begin
         ins = prog[pc];
         rs  = ins[25:21];
         rt  = ins[20:16];
         rd  = ins[15:11];
         imm = ins[15:0];
         a   = modelRegs[rs];
         b   = modelRegs[rt];
         ext = {{16{imm[15]}}, imm};
         // Word index, alignment ignored
         idx = int'((a + ext) % dmemWords);
         pc++;
         case (ins[31:26])
            mipsPkg::opcR: begin
               case (ins[5:0])
                  mipsPkg::fnSub: res = a - b;
                  mipsPkg::fnAnd: res = a & b;
                  mipsPkg::fnOr:  res = a | b;
                  mipsPkg::fnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  default:        res = a + b;
               endcase
               writeModelReg(rd, res);
            end
            mipsPkg::opcLw: writeModelReg(rt, modelMem[idx]);
            mipsPkg::opcSw: begin
               modelMem[idx] = b;
               expStAddr.push_back(mipsPkg::wordT'(idx));
               expStData.push_back(b);
            end
            mipsPkg::opcBeq: begin
               if (a == b) begin
                  pc = pc + int'($signed(imm));
               end
            end
            default: ;
         endcase
      end
   endtask

   task automatic checkWb(input mipsPkg::regIdxT gotReg, input mipsPkg::wordT gotData);
      mipsPkg::regIdxT expReg;
      mipsPkg::wordT   expData;
      if (expWbReg.size() == 0) begin
         $display("Unexpected writeback to r%0d after the model ran out of writebacks", gotReg);
         eventErrors++;
      end else begin
         expReg  = expWbReg.pop_front();
         expData = expWbData.pop_front();
         if (gotReg !== expReg) begin
            $display("Fail wbReg: got %h, expected %h", gotReg, expReg);
            valueErrors++;
         end
         if (gotData !== expData) begin
            $display("Fail wbData: got %h, expected %h", gotData, expData);
            valueErrors++;
         end
      end
   endtask

   task automatic checkStore(input mipsPkg::wordT gotAddr, input mipsPkg::wordT gotData);
      mipsPkg::wordT expAddr;
      mipsPkg::wordT expData;
      if (expStAddr.size() == 0) begin
         $display("Unexpected store to word %0d after the model ran out of stores", gotAddr);
         eventErrors++;
      end else begin
         expAddr = expStAddr.pop_front();
         expData = expStData.pop_front();
         if (gotAddr !== expAddr) begin
            $display("Fail memAddr: got %h, expected %h", gotAddr, expAddr);
            valueErrors++;
         end
         if (gotData !== expData) begin
            $display("Fail memData: got %h, expected %h", gotData, expData);
            valueErrors++;
         end
      end
   endtask

   // Sample mid-cycle, away from the driving edge
   always @(negedge Clk) begin
      if (!run && (wbValid || memWrEn)) begin
         $display("Writeback or store strobe seen while the core is in reset or idle");
         eventErrors++;
      end else if (wbValid && wbReg == '0) begin
         $display("Writeback reported for register 0");
         eventErrors++;
      end else begin
         if (wbValid) begin
            checkWb(wbReg, wbData);
         end
         if (memWrEn) begin
            checkStore(memAddr, memData);
         end
      end
   end

   initial begin
      rstN     = 1'b0;
      run      = 1'b0;
      imemWrEn = 1'b0;
      imemAddr = '0;
      imemData = '0;
      lcgState = 32'h93c3;
      missing  = 0;
      cycles   = 0;
      genProgram();
      for (int i = 0; i < 32; i++) begin
         modelRegs[i] = '0;
      end
      for (int i = 0; i < dmemWords; i++) begin
         modelMem[i] = fillWord(i);
      end
      runModel();
      repeat (16) @(posedge Clk);
      // Backdoor data fill so loads bring nonzero words into the registers
      for (int i = 0; i < dmemWords; i++) begin
         mipsCore_i.memoryStage_i.dmem[i] = fillWord(i);
      end
      #1 rstN = 1'b1;
      // Program through the load port, one word per cycle
      for (int i = 0; i <= progLen; i++) begin
         @(posedge Clk);
         #1;
         imemWrEn = 1'b1;
         imemAddr = mipsPkg::wordT'(i);
         imemData = prog[i];
      end
      @(posedge Clk);
      #1;
      imemWrEn = 1'b0;
      run      = 1'b1;
      while ((expWbReg.size() != 0 || expStAddr.size() != 0) && cycles < runLimit) begin
         @(posedge Clk);
         cycles++;
      end
      if (expWbReg.size() != 0 || expStAddr.size() != 0) begin
         missing = expWbReg.size() + expStAddr.size();
         $display("Timeout after %0d cycles, %0d writebacks and %0d stores never appeared",
                  cycles, expWbReg.size(), expStAddr.size());
      end else begin
         // Self-loop spinning, nothing more may appear
         repeat (quietCycles) @(posedge Clk);
      end
      $display("Errors: %0d wrong values, %0d unexpected events, %0d missing events",
               valueErrors, eventErrors, missing);
      if (valueErrors == 0 && eventErrors == 0 && missing == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// File: mipsPkg.sv
// Core widths, instruction field types, opcodes, function codes, ALU codes, forward selects
package mipsPkg;

   // Data, instruction and byte address word
   typedef logic [31:0] wordT;
   // Register index
   typedef logic [4:0] regIdxT;
   // Raw I-type immediate
   typedef logic [15:0] immT;
   // Primary opcode, bits 31..26
   typedef logic [5:0] opcodeT;
   // R-type function, bits 5..0
   typedef logic [5:0] functT;
   // ALU operation select
   typedef logic [2:0] aluCtrlT;
   // EX operand source
   typedef logic [1:0] fwdSelT;

   // Opcodes of the kept subset
   localparam opcodeT opcR   = 6'h00;
   localparam opcodeT opcLw  = 6'h23;
   localparam opcodeT opcSw  = 6'h2b;
   localparam opcodeT opcBeq = 6'h04;

   // R-type functions
   localparam functT fnAdd = 6'h20;
   localparam functT fnSub = 6'h22;
   localparam functT fnAnd = 6'h24;
   localparam functT fnOr  = 6'h25;
   localparam functT fnSlt = 6'h2a;

   // ALU operations
   localparam aluCtrlT aluAdd = 3'd0;
   localparam aluCtrlT aluSub = 3'd1;
   localparam aluCtrlT aluAnd = 3'd2;
   localparam aluCtrlT aluOr  = 3'd3;
   localparam aluCtrlT aluSlt = 3'd4;

   // Forward sources
   // Register value read in decode
   localparam fwdSelT fwdNone = 2'b00;
   // ALU result sitting in MEM
   localparam fwdSelT fwdMem  = 2'b10;
   // Writeback data in WB
   localparam fwdSelT fwdWb   = 2'b01;

endpackage

// File: regFile.sv
// Register file, 32 x 32 bits, r0 fixed at zero, write-before-read bypass
`timescale 1ns/10ps
module regFile (
   input  logic            Clk,
   input  logic            rstN,
   input  mipsPkg::regIdxT rdAddrA,
   input  mipsPkg::regIdxT rdAddrB,
   input  logic            wrEn,
   input  mipsPkg::regIdxT wrAddr,
   input  mipsPkg::wordT   wrData,
   output mipsPkg::wordT   rdDataA,
   output mipsPkg::wordT   rdDataB
);
   mipsPkg::wordT regs [32];

   // Architectural state starts at zero
   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn && wrAddr != '0) begin
         regs[wrAddr] <= wrData;
      end
   end

   // r0 first, then the word being written this cycle
   function automatic mipsPkg::wordT readPort(input mipsPkg::regIdxT addr);
      if (addr == '0) begin
         return '0;
      end
      if (wrEn && wrAddr == addr) begin
         return wrData;
      end
      return regs[addr];
   endfunction

   always_comb begin
      rdDataA = readPort(rdAddrA);
      rdDataB = readPort(rdAddrB);
   end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module mipsCore_tb -o simv
./obj_dir/simv | tee sim.log
if grep -qF '*** PASSED ***' sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed, see sim.log"
   exit 1
fi

// File: sim.f
mipsPkg.sv
fetchStage.sv
regFile.sv
decodeStage.sv
hazardUnit.sv
executeStage.sv
memoryStage.sv
mipsCore.sv
mipsCore_chk.sv
mipsCore_tb.sv
